//--- fpuPkg.sv
package fpuPkg;

	localparam int fprWidth = 64;
	localparam int opWidth = 6;

	// anything but these opcodes acts as a nop
	localparam logic [opWidth-1:0] ucmdNop = 6'h00;
	localparam logic [opWidth-1:0] ucmdFldcx = 6'h14;
	localparam logic [opWidth-1:0] ucmdFstcx = 6'h15;

	// condition codes against SR.T
	localparam logic [1:0] ccAlways = 2'b00;
	localparam logic [1:0] ccNever = 2'b01;
	localparam logic [1:0] ccTrue = 2'b10;
	localparam logic [1:0] ccFalse = 2'b11;

	// execute status levels
	localparam logic [1:0] statusReady = 2'd0;
	localparam logic [1:0] statusOk = 2'd1;
	localparam logic [1:0] statusHold = 2'd2;

	// packed store sequencing
	localparam int holdBits = 2;
	localparam logic [holdBits-1:0] packedSteps = 2'd2;

	typedef struct packed {
		logic [1:0] cc;
		logic [opWidth-1:0] op;
		logic [7:0] ixt;	// sub-op in low bits
	} fpuCmd;

	typedef enum logic [3:0] {
		uopNone = 4'd0,
		uopMove = 4'd1,
		uopS2D = 4'd2,
		uopH2D = 4'd3,
		uopD2S = 4'd4,
		uopD2H = 4'd5,
		uopPackS = 4'd6
	} uopKind;

	typedef struct packed {
		uopKind kind;
		logic hiWord;	// high word of rs for single loads
		logic [fprWidth-1:0] rs;
		logic [fprWidth-1:0] rt;
	} fpuUop;

	typedef struct packed {
		logic sign;
		logic [10:0] exponent;
		logic [51:0] fraction;
	} fpDouble;

	typedef struct packed {
		logic sign;
		logic [7:0] exponent;
		logic [22:0] fraction;
	} fpSingle;

	typedef struct packed {
		logic sign;
		logic [4:0] exponent;
		logic [9:0] fraction;
	} fpHalf;

endpackage

//--- fpWiden.sv
module fpWiden #(
	parameter type srcT = fpuPkg::fpSingle
) (
	input srcT src,
	output fpuPkg::fpDouble dst
);

	localparam int expBits = $bits(src.exponent);
	localparam int fracBits = $bits(src.fraction);
	localparam int dstExpBits = $bits(dst.exponent);
	localparam int dstFracBits = $bits(dst.fraction);
	localparam int srcBias = (1 << (expBits - 1)) - 1;
	localparam int dstBias = (1 << (dstExpBits - 1)) - 1;

	logic [dstExpBits-1:0] rebiased;
	logic [dstFracBits-1:0] fracAligned;

	// always fits since the double range covers the source range
	assign rebiased = dstExpBits'(src.exponent) + dstExpBits'(dstBias - srcBias);
	assign fracAligned = {src.fraction, {(dstFracBits - fracBits){1'b0}}};

	always_comb begin
		dst.sign = src.sign;
		if (src.exponent == '0) begin
			// zero and denormals collapse to signed zero
			dst.exponent = '0;
			dst.fraction = '0;
		end else if (&src.exponent) begin
			dst.exponent = '1;	// inf or nan
			dst.fraction = fracAligned;
		end else begin
			dst.exponent = rebiased;
			dst.fraction = fracAligned;
		end
	end

endmodule

//--- fpNarrow.sv
module fpNarrow #(
	parameter type dstT = fpuPkg::fpSingle
) (
	input fpuPkg::fpDouble src,
	output dstT dst
);

	localparam int expBits = $bits(dst.exponent);
	localparam int fracBits = $bits(dst.fraction);
	localparam int srcExpBits = $bits(src.exponent);
	localparam int srcFracBits = $bits(src.fraction);
	localparam int wideBits = srcExpBits + 2;
	localparam int dstBias = (1 << (expBits - 1)) - 1;
	localparam int srcBias = (1 << (srcExpBits - 1)) - 1;
	localparam int expMax = (1 << expBits) - 1;
	localparam int expLow = srcBias - dstBias + 1;
	localparam int expHigh = srcBias - dstBias + expMax - 1;

	logic signed [wideBits-1:0] newExp;	// rebiased and possibly out of range
	logic [fracBits-1:0] fracTop;
	logic inRange;

	assign newExp = $signed({2'b00, src.exponent}) - wideBits'(srcBias - dstBias);
	assign fracTop = src.fraction[srcFracBits-1 -: fracBits];

	// source exponents that land on a finite normal result
	assign inRange = (src.exponent >= srcExpBits'(expLow))
		&& (src.exponent <= srcExpBits'(expHigh));

	always_comb begin
		dst.sign = src.sign;
		if (&src.exponent) begin
			dst.exponent = '1;
			dst.fraction = fracTop;
			// nan must stay nan after truncation
			if (src.fraction != '0)
				dst.fraction[fracBits-1] = 1'b1;
		end else if (newExp < 1) begin
			dst.exponent = '0;	// underflow flushes
			dst.fraction = '0;
		end else if (newExp >= expMax) begin
			dst.exponent = '1;	// overflow to inf
			dst.fraction = '0;
		end else begin
			dst.exponent = newExp[expBits-1:0];
			dst.fraction = fracTop;
		end

		assert (!(inRange && (&dst.exponent)))
			else $error("in-range double narrowed to inf/nan exponent");
	end

endmodule

//--- fpuDecode.sv
module fpuDecode (
	input logic clock,
	input logic reset,
	input fpuPkg::fpuCmd cmd,
	input logic [fpuPkg::fprWidth-1:0] rs,
	input logic [fpuPkg::fprWidth-1:0] rt,
	input logic srT,
	input logic braFlush,
	input logic exHold,
	input logic busy,
	output fpuPkg::fpuUop uop
);

	fpuPkg::fpuCmd cmdL;
	logic [fpuPkg::fprWidth-1:0] rsL;
	logic [fpuPkg::fprWidth-1:0] rtL;
	logic srTL;
	logic flushL;
	logic enable;
	logic sample;
	fpuPkg::uopKind kind;

	assign sample = !exHold && !busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			cmdL <= '{cc: fpuPkg::ccAlways, op: fpuPkg::ucmdNop, ixt: '0};
			srTL <= 1'b0;
			flushL <= 1'b0;
		end else if (sample) begin
			cmdL <= cmd;
			srTL <= srT;
			flushL <= braFlush;
		end
	end

	always_ff @(posedge clock) begin
		if (sample) begin
			rsL <= rs;
			rtL <= rt;
		end
	end

	always_comb begin
		case (cmdL.cc)
			fpuPkg::ccAlways: enable = 1'b1;
			fpuPkg::ccNever: enable = 1'b0;
			fpuPkg::ccTrue: enable = srTL;
			default: enable = !srTL;	// ccFalse
		endcase
		if (flushL)
			enable = 1'b0;
	end

	always_comb begin
		kind = fpuPkg::uopNone;
		if (enable) begin
			case (cmdL.op)
				fpuPkg::ucmdFldcx: begin
					// sub-op 8 is sub-op 0 with the high word selected
					case (cmdL.ixt[3:0])
						4'h0, 4'h8: kind = fpuPkg::uopS2D;
						4'h1: kind = fpuPkg::uopMove;
						4'h3: kind = fpuPkg::uopH2D;
						default: kind = fpuPkg::uopNone;
					endcase
				end
				fpuPkg::ucmdFstcx: begin
					case (cmdL.ixt[3:0])
						4'h0: kind = fpuPkg::uopD2S;
						4'h1: kind = fpuPkg::uopMove;
						4'h3: kind = fpuPkg::uopD2H;
						4'h8: kind = fpuPkg::uopPackS;
						default: kind = fpuPkg::uopNone;
					endcase
				end
				default: kind = fpuPkg::uopNone;
			endcase
		end
	end

	assign uop = '{kind: kind, hiWord: cmdL.ixt[3], rs: rsL, rt: rtL};

	// a command sampled with a flush never reaches execute
	assert property (@(posedge clock) disable iff (reset)
		(braFlush && sample) |=> (uop.kind == fpuPkg::uopNone))
		else $error("flushed command was not squashed");

endmodule

//--- fpuExecute.sv
module fpuExecute (
	input logic clock,
	input logic reset,
	input fpuPkg::fpuUop uop,
	input logic exHold,
	output logic busy,
	output logic [fpuPkg::fprWidth-1:0] convValue
);

	logic [fpuPkg::holdBits-1:0] holdCount;
	fpuPkg::fpSingle singleIn;
	fpuPkg::fpHalf halfIn;
	fpuPkg::fpDouble s2dValue;
	fpuPkg::fpDouble h2dValue;
	fpuPkg::fpDouble narrowIn;
	fpuPkg::fpSingle narrowS;
	fpuPkg::fpHalf narrowH;
	fpuPkg::fpSingle partialS;	// rs half of a packed store

	assign singleIn = uop.hiWord ? uop.rs[63:32] : uop.rs[31:0];
	assign halfIn = uop.rs[15:0];

	fpWiden #(.srcT(fpuPkg::fpSingle)) singleWiden (
		.src(singleIn),
		.dst(s2dValue)
	);

	fpWiden #(.srcT(fpuPkg::fpHalf)) halfWiden (
		.src(halfIn),
		.dst(h2dValue)
	);

	// one single narrower shared by D2S and both packed steps
	assign narrowIn = (holdCount == '0) ? uop.rs : uop.rt;

	fpNarrow #(.dstT(fpuPkg::fpSingle)) singleNarrow (
		.src(narrowIn),
		.dst(narrowS)
	);

	fpNarrow #(.dstT(fpuPkg::fpHalf)) halfNarrow (
		.src(uop.rs),
		.dst(narrowH)
	);

	assign busy = (uop.kind == fpuPkg::uopPackS) && (holdCount < fpuPkg::packedSteps);

	always_ff @(posedge clock) begin
		if (reset)
			holdCount <= '0;
		else if (!exHold) begin
			if (busy)
				holdCount <= holdCount + 2'd1;
			else
				holdCount <= '0;	// ready for the next command
		end
	end

	always_ff @(posedge clock) begin
		if (!exHold && uop.kind == fpuPkg::uopPackS && holdCount == '0)
			partialS <= narrowS;
	end

	always_comb begin
		case (uop.kind)
			fpuPkg::uopMove: convValue = uop.rs;
			fpuPkg::uopS2D: convValue = s2dValue;
			fpuPkg::uopH2D: convValue = h2dValue;
			fpuPkg::uopD2S: convValue = fpuPkg::fprWidth'(narrowS);
			fpuPkg::uopD2H: convValue = fpuPkg::fprWidth'(narrowH);
			fpuPkg::uopPackS: convValue = {narrowS, partialS};	// rt high and rs low
			default: convValue = '0;
		endcase
	end

	assert property (@(posedge clock) disable iff (reset)
		holdCount <= fpuPkg::packedSteps)
		else $error("packed store counter overran");

endmodule

//--- fpuResult.sv
module fpuResult (
	input fpuPkg::fpuUop uop,
	input logic busy,
	input logic [fpuPkg::fprWidth-1:0] convValue,
	output logic [fpuPkg::fprWidth-1:0] grn,
	output logic [1:0] outOk
);

	logic defined;

	assign defined = (uop.kind != fpuPkg::uopNone);

	// disabled or unknown commands return zero
	assign grn = defined ? convValue : '0;

	always_comb begin
		if (busy)
			outOk = fpuPkg::statusHold;
		else if (defined)
			outOk = fpuPkg::statusOk;
		else
			outOk = fpuPkg::statusReady;

		assert (outOk != fpuPkg::statusHold || uop.kind == fpuPkg::uopPackS)
			else $error("hold status without a packed store");
	end

endmodule

//--- fpuExOp.sv
module fpuExOp (
	input logic clock,
	input logic reset,
	input fpuPkg::fpuCmd cmd,
	input logic [fpuPkg::fprWidth-1:0] rs,
	input logic [fpuPkg::fprWidth-1:0] rt,
	input logic srT,
	input logic braFlush,
	input logic exHold,
	output logic [fpuPkg::fprWidth-1:0] grn,
	output logic [1:0] outOk
);

	fpuPkg::fpuUop uop;
	logic busy;	// packed store in progress
	logic [fpuPkg::fprWidth-1:0] convValue;

	fpuDecode decode (
		.clock(clock),
		.reset(reset),
		.cmd(cmd),
		.rs(rs),
		.rt(rt),
		.srT(srT),
		.braFlush(braFlush),
		.exHold(exHold),
		.busy(busy),
		.uop(uop)
	);

	fpuExecute execute (
		.clock(clock),
		.reset(reset),
		.uop(uop),
		.exHold(exHold),
		.busy(busy),
		.convValue(convValue)
	);

	fpuResult result (
		.uop(uop),
		.busy(busy),
		.convValue(convValue),
		.grn(grn),
		.outOk(outOk)
	);

endmodule

//--- fpuExOpTb.sv
module fpuExOpTb;

	localparam int holdTimeout = 20;	// cycles allowed in HOLD
	localparam int resetCycles = 5;

	// one pattern line after parsing
	typedef struct packed {
		logic [127:0] tag;
		fpuPkg::fpuCmd cmd;
		logic [63:0] rs;
		logic [63:0] rt;
		logic srT;
		logic flush;
		logic [63:0] grn;
		logic [1:0] status;
	} vectorRec;

	logic clock;
	logic reset;
	fpuPkg::fpuCmd cmd;
	logic [63:0] rs;
	logic [63:0] rt;
	logic srT;
	logic braFlush;
	logic exHold;
	logic [63:0] grn;
	logic [1:0] outOk;

	logic [31:0] lfsrState;
	int errorCount;
	int testCount;
	int testErrors;

	fpuExOp DUT (
		.clock(clock),
		.reset(reset),
		.cmd(cmd),
		.rs(rs),
		.rt(rt),
		.srT(srT),
		.braFlush(braFlush),
		.exHold(exHold),
		.grn(grn),
		.outOk(outOk)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// galois form with taps 32 30 26 25
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 32'hA3000000;
		return next;
	endfunction

	task automatic drawStall(output int stall);
		stall = 0;
		for (int i = 0; i < 2; i++) begin
			stall = (stall << 1) | int'(lfsrState[0]);
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic compare(input logic [127:0] tag, input string field,
			input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual) begin
			$display("mismatch in %0s, %0s: expected %h, actual %h",
				tag, field, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic driveIdle();
		cmd = '{cc: fpuPkg::ccAlways, op: fpuPkg::ucmdNop, ixt: 8'h00};
		rs = '0;
		rt = '0;
		srT = 1'b0;
		braFlush = 1'b0;
	endtask

	task automatic reportTest(input logic [127:0] tag);
		testCount++;
		if (testErrors == 0)
			$display("%0s: ok", tag);
		else
			$display("%0s: %0d errors", tag, testErrors);
	endtask

	// entered and left on a falling edge with the DUT not busy
	task automatic runTest(input vectorRec vec, output logic timedOut);
		int stall;
		int holds;
		int expHolds;
		logic [63:0] heldGrn;
		logic [1:0] heldOk;

		timedOut = 1'b0;
		testErrors = 0;
		cmd = vec.cmd;
		rs = vec.rs;
		rt = vec.rt;
		srT = vec.srT;
		braFlush = vec.flush;
		@(posedge clock);
		@(negedge clock);
		driveIdle();

		// random stall right after the sample
		drawStall(stall);
		heldGrn = grn;
		heldOk = outOk;
		exHold = (stall > 0);
		for (int i = 0; i < stall; i++) begin
			@(negedge clock);
			compare(vec.tag, "grn under exHold", heldGrn, grn);
			compare(vec.tag, "outOk under exHold", 64'(heldOk), 64'(outOk));
		end
		exHold = 1'b0;

		holds = 0;
		while (outOk == fpuPkg::statusHold && holds < holdTimeout) begin
			holds++;
			@(negedge clock);
		end

		if (outOk == fpuPkg::statusHold) begin
			$display("%0s: outOk still HOLD after %0d cycles", vec.tag, holdTimeout);
			timedOut = 1'b1;
			errorCount++;
			testErrors++;
		end else begin
			// only an enabled packed store holds
			if (vec.status == fpuPkg::statusOk && vec.cmd.op == fpuPkg::ucmdFstcx
					&& vec.cmd.ixt[3:0] == 4'h8)
				expHolds = 2;
			else
				expHolds = 0;
			compare(vec.tag, "hold cycles", 64'(expHolds), 64'(holds));
			compare(vec.tag, "grn", vec.grn, grn);
			compare(vec.tag, "outOk", 64'(vec.status), 64'(outOk));
		end
		reportTest(vec.tag);
	endtask

	initial begin
		int fd;
		int count;
		logic [8*128-1:0] line;
		logic [127:0] tag;
		logic [7:0] ccV;
		logic [7:0] opV;
		logic [7:0] ixtV;
		logic srTV;
		logic flushV;
		logic [63:0] rsV;
		logic [63:0] rtV;
		logic [63:0] grnV;
		logic [1:0] okV;
		vectorRec vec;
		logic timedOut;

		lfsrState = 32'hf0c1;
		errorCount = 0;
		testCount = 0;
		timedOut = 1'b0;
		exHold = 1'b0;
		reset = 1'b1;
		driveIdle();
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		testErrors = 0;
		compare(128'("afterReset"), "grn", 64'h0, grn);
		compare(128'("afterReset"), "outOk", 64'(fpuPkg::statusReady), 64'(outOk));
		reportTest(128'("afterReset"));

		fd = $fopen("fpuPatterns.hex", "r");
		if (fd == 0) begin
			$display("could not open fpuPatterns.hex");
			errorCount++;
		end else begin
			while (!timedOut && $fgets(line, fd) != 0) begin
				tag = '0;
				count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", tag, ccV, opV,
					ixtV, srTV, flushV, rsV, rtV, grnV, okV);
				if (count == 10) begin
					vec.tag = tag;
					vec.cmd = '{cc: ccV[1:0], op: opV[5:0], ixt: ixtV};
					vec.rs = rsV;
					vec.rt = rtV;
					vec.srT = srTV;
					vec.flush = flushV;
					vec.grn = grnV;
					vec.status = okV;
					runTest(vec, timedOut);
				end else if (count > 0 && tag != 128'("#")) begin
					$display("malformed pattern line: %0s", line);
					errorCount++;
				end
			end
			$fclose(fd);
		end

		$display("%0d tests run, %0d errors", testCount, errorCount);
		if (errorCount == 0 && !timedOut) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- fpuPatterns.hex
# tag cc op ixt srT flush rs rt expectedGrn expectedStatus
# all fields hex, status 0 ready 1 ok 2 hold
s2dLo 0 14 00 0 0 C0490FDB3F800000 0000000000000000 3FF0000000000000 1
s2dHi 0 14 08 0 0 C0490FDB3F800000 0000000000000000 C00921FB60000000 1
s2dDenLo 0 14 00 0 0 8000000100400000 0000000000000000 0000000000000000 1
s2dDenHi 0 14 08 0 0 8000000100400000 0000000000000000 8000000000000000 1
s2dInf 0 14 00 0 0 000000007F800000 0000000000000000 7FF0000000000000 1
s2dNan 0 14 08 0 0 7FC0000000000000 0000000000000000 7FF8000000000000 1
h2dOne 0 14 03 0 0 1234567800003C00 0000000000000000 3FF0000000000000 1
h2dNeg 0 14 03 0 0 000000000000C500 0000000000000000 C014000000000000 1
h2dMax 0 14 03 0 0 0000000000007BFF 0000000000000000 40EFFC0000000000 1
h2dDen 0 14 03 0 0 00000000000083FF 0000000000000000 8000000000000000 1
d2sOne 0 15 00 0 0 3FF0000000000000 0000000000000000 000000003F800000 1
d2sPi 0 15 00 0 0 400921FB54442D18 0000000000000000 0000000040490FDA 1
d2sMinNorm 0 15 00 0 0 3810000000000000 0000000000000000 0000000000800000 1
d2sUnder 0 15 00 0 0 3800000000000000 0000000000000000 0000000000000000 1
d2sUnderNeg 0 15 00 0 0 B000000000000000 0000000000000000 0000000080000000 1
d2sMaxNorm 0 15 00 0 0 47EFFFFFE0000000 0000000000000000 000000007F7FFFFF 1
d2sOver 0 15 00 0 0 C7F0000000000000 0000000000000000 00000000FF800000 1
d2sInf 0 15 00 0 0 7FF0000000000000 0000000000000000 000000007F800000 1
d2sNanLow 0 15 00 0 0 7FF0000000000001 0000000000000000 000000007FC00000 1
d2sNanNeg 0 15 00 0 0 FFF4000000000000 0000000000000000 00000000FFE00000 1
d2hOne 0 15 03 0 0 3FF0000000000000 0000000000000000 0000000000003C00 1
d2hNeg 0 15 03 0 0 C014000000000000 0000000000000000 000000000000C500 1
d2hTrunc 0 15 03 0 0 40EFFFFFFFFFFFFF 0000000000000000 0000000000007BFF 1
d2hOver 0 15 03 0 0 40F0000000000000 0000000000000000 0000000000007C00 1
d2hMinNorm 0 15 03 0 0 3F10000000000000 0000000000000000 0000000000000400 1
d2hUnderNeg 0 15 03 0 0 BF00000000000000 0000000000000000 0000000000008000 1
d2hNan 0 15 03 0 0 7FF0000100000000 0000000000000000 0000000000007E00 1
d2hInfNeg 0 15 03 0 0 FFF0000000000000 0000000000000000 000000000000FC00 1
packA 0 15 08 0 0 3FF0000000000000 400921FB54442D18 40490FDA3F800000 1
packB 0 15 08 0 0 C014000000000000 7FF0000000000000 7F800000C0A00000 1
movLd 0 14 01 0 0 0123456789ABCDEF 0000000000000000 0123456789ABCDEF 1
movSt 0 15 01 0 0 FEDCBA9876543210 0000000000000000 FEDCBA9876543210 1
ccNever 1 14 01 0 0 0123456789ABCDEF 0000000000000000 0000000000000000 0
ccTrueOff 2 14 01 0 0 0123456789ABCDEF 0000000000000000 0000000000000000 0
ccTrueOn 2 14 01 1 0 0123456789ABCDEF 0000000000000000 0123456789ABCDEF 1
ccFalseOff 3 14 01 1 0 0123456789ABCDEF 0000000000000000 0000000000000000 0
ccFalseOn 3 14 01 0 0 0123456789ABCDEF 0000000000000000 0123456789ABCDEF 1
flushMov 0 14 01 0 1 0123456789ABCDEF 0000000000000000 0000000000000000 0
flushPack 0 15 08 0 1 3FF0000000000000 400921FB54442D18 0000000000000000 0
neverPack 1 15 08 0 0 3FF0000000000000 400921FB54442D18 0000000000000000 0
ccTruePack 2 15 08 1 0 3FF0000000000000 400921FB54442D18 40490FDA3F800000 1
badOp 0 3F 01 0 0 0123456789ABCDEF 0000000000000000 0000000000000000 0
nopOp 0 00 00 0 0 0123456789ABCDEF 0000000000000000 0000000000000000 0
badLdSub 0 14 02 0 0 0123456789ABCDEF 0000000000000000 0000000000000000 0
badStSub 0 15 0F 0 0 0123456789ABCDEF 0000000000000000 0000000000000000 0

//--- build.f
fpuPkg.sv
fpWiden.sv
fpNarrow.sv
fpuDecode.sv
fpuExecute.sv
fpuResult.sv
fpuExOp.sv
fpuExOpTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f build.f --top-module fpuExOpTb -Mdir obj_dir
	obj_dir/VfpuExOpTb | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir
